//--- src/msx_mem_pkg.sv
package msx_mem_pkg;

   localparam int MEM_ADDR_W = 25;
   localparam int DL_ADDR_W  = 27;
   localparam int SD_BLOCK_W = 9;   // 512 byte SD blocks

   // Region RAMs take the wider of CPU and download addressing
   localparam int RGN_ADDR_W = (MEM_ADDR_W > DL_ADDR_W) ? MEM_ADDR_W : DL_ADDR_W;

   typedef enum logic [2:0] {
      MEM_BIOS   = 3'd0,
      MEM_RAM    = 3'd1,
      MEM_CART_A = 3'd2,
      MEM_CART_B = 3'd3,
      MEM_SRAM   = 3'd4
   } mem_port_e;

   localparam int MEM_PORTS = 5;

   typedef struct packed {
      logic [MEM_ADDR_W-1:0] addr;
      logic [7:0]            wdata;
      logic                  wren;
      logic                  rden;
   } mem_req_t;

   // Host download channel
   typedef struct packed {
      logic                 active;
      logic [15:0]          index;
      logic                 wr;
      logic [DL_ADDR_W-1:0] addr;
      logic [7:0]           dout;
   } dl_req_t;

   typedef enum logic [1:0] {DL_NONE, DL_BIOS, DL_CART} dl_target_e;

   typedef struct packed {
      dl_target_e target;
      logic       slot;   // Cartridge slot, 0 is A
   } dl_route_t;

endpackage

//--- src/download_decode.sv
`timescale 1ns/1ps

module download_decode (
   input  msx_mem_pkg::dl_req_t   dl,
   output msx_mem_pkg::dl_route_t route,
   output logic                   reset_req
);

   always_comb begin
      route.target = msx_mem_pkg::DL_NONE;
      route.slot   = 1'b0;
      if (dl.active) begin
         case (dl.index[5:0])
            6'd1: begin
               route.target = msx_mem_pkg::DL_BIOS;
            end
            6'd6, 6'd8: begin   // ROM or firmware image for slot A
               route.target = msx_mem_pkg::DL_CART;
               route.slot   = 1'b0;
            end
            6'd7, 6'd9: begin
               route.target = msx_mem_pkg::DL_CART;
               route.slot   = 1'b1;
            end
            6'd0: begin
               // Boot file entry, only sub-index 0 is the BIOS
               if (dl.index[15:6] == 10'd0) begin
                  route.target = msx_mem_pkg::DL_BIOS;
               end
            end
            default: begin
               route.target = msx_mem_pkg::DL_NONE;
            end
         endcase
      end
   end

   // Core held in reset while a known image streams in
   assign reset_req = route.target != msx_mem_pkg::DL_NONE;

endmodule

//--- src/region_ram.sv
`timescale 1ns/1ps

module region_ram #(
   parameter int AW = 15
) (
   input  logic                               clk,
   input  logic [msx_mem_pkg::RGN_ADDR_W-1:0] addr,
   input  logic [7:0]                         wdata,
   input  logic                               wren,
   input  logic                               rden,
   output logic [7:0]                         q
);

   logic [7:0] mem [2**AW];
   logic [7:0] rd_data;
   logic       rd_ok;
   logic       in_range;

   assign in_range = addr[msx_mem_pkg::RGN_ADDR_W-1:AW] == '0;

   always_ff @(posedge clk) begin
      if (wren && in_range) begin
         mem[addr[AW-1:0]] <= wdata;
      end
      rd_data <= mem[addr[AW-1:0]];
      rd_ok   <= rden && in_range;   // Aligned with rd_data
   end

   assign q = rd_ok ? rd_data : 8'hFF;

endmodule

//--- src/cart_enable_regs.sv
`timescale 1ns/1ps

module cart_enable_regs (
   input  logic                   clk,
   input  logic                   rst,
   input  msx_mem_pkg::dl_route_t route,
   input  logic [1:0]             cart_wren,
   input  logic [1:0]             cart_changed,
   input  logic                   image_detach,
   output logic [1:0]             slot_en
);

   logic [1:0] set_en;
   logic [1:0] clr_en;

   always_comb begin
      for (int i = 0; i < 2; i++) begin
         // Download into the slot or CPU write to its port
         set_en[i] = (route.target == msx_mem_pkg::DL_CART && route.slot == i[0])
                     || cart_wren[i];
         clr_en[i] = image_detach || cart_changed[i];
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         slot_en <= 2'b00;
      end else begin
         for (int i = 0; i < 2; i++) begin
            slot_en[i] <= set_en[i] || (slot_en[i] && !clr_en[i]);   // Set wins
         end
      end
   end

endmodule

//--- src/memory_map.sv
`timescale 1ns/1ps

module memory_map #(
   parameter int BIOS_AW   = 15,
   parameter int RAM_AW    = 16,
   parameter int CART_A_AW = 17,
   parameter int CART_B_AW = 16
) (
   input  logic                   clk,
   input  msx_mem_pkg::dl_req_t   dl,
   input  msx_mem_pkg::dl_route_t route,
   input  logic [1:0]             slot_en,
   input  msx_mem_pkg::mem_req_t  bios_req,
   input  msx_mem_pkg::mem_req_t  ram_req,
   input  msx_mem_pkg::mem_req_t  cart_a_req,
   input  msx_mem_pkg::mem_req_t  cart_b_req,
   output logic [7:0]             bios_q,
   output logic [7:0]             ram_q,
   output logic [7:0]             cart_a_q,
   output logic [7:0]             cart_b_q
);

   localparam int RW     = msx_mem_pkg::RGN_ADDR_W;
   localparam int R_BIOS = 0;
   localparam int R_RAM  = 1;
   localparam int R_CA   = 2;
   localparam int R_CB   = 3;

   msx_mem_pkg::mem_req_t [3:0] cpu_req;
   logic [3:0]                  dl_sel;
   logic [3:0][RW-1:0]          rgn_addr;
   logic [3:0][7:0]             rgn_wdata;
   logic [3:0]                  rgn_wren;
   logic [3:0]                  rgn_rden;
   logic [3:0][7:0]             rgn_q;
   logic [1:0]                  slot_en_q;

   assign cpu_req = {cart_b_req, cart_a_req, ram_req, bios_req};

   assign dl_sel[R_BIOS] = route.target == msx_mem_pkg::DL_BIOS;
   assign dl_sel[R_RAM]  = 1'b0;   // Main RAM is never a download target
   assign dl_sel[R_CA]   = route.target == msx_mem_pkg::DL_CART && !route.slot;
   assign dl_sel[R_CB]   = route.target == msx_mem_pkg::DL_CART && route.slot;

   // Download owns the region while routed to it, CPU is locked out
   always_comb begin
      for (int i = 0; i < 4; i++) begin
         if (dl_sel[i]) begin
            rgn_addr[i]  = RW'(dl.addr);
            rgn_wdata[i] = dl.dout;
            rgn_wren[i]  = dl.wr;
            rgn_rden[i]  = 1'b0;
         end else begin
            rgn_addr[i]  = RW'(cpu_req[i].addr);
            rgn_wdata[i] = cpu_req[i].wdata;
            rgn_wren[i]  = cpu_req[i].wren;
            rgn_rden[i]  = cpu_req[i].rden;
         end
      end
   end

   region_ram #(.AW(BIOS_AW)) u_bios (
      .clk   (clk),
      .addr  (rgn_addr[R_BIOS]),
      .wdata (rgn_wdata[R_BIOS]),
      .wren  (rgn_wren[R_BIOS]),
      .rden  (rgn_rden[R_BIOS]),
      .q     (rgn_q[R_BIOS])
   );

   region_ram #(.AW(RAM_AW)) u_ram (
      .clk   (clk),
      .addr  (rgn_addr[R_RAM]),
      .wdata (rgn_wdata[R_RAM]),
      .wren  (rgn_wren[R_RAM]),
      .rden  (rgn_rden[R_RAM]),
      .q     (rgn_q[R_RAM])
   );

   region_ram #(.AW(CART_A_AW)) u_cart_a (
      .clk   (clk),
      .addr  (rgn_addr[R_CA]),
      .wdata (rgn_wdata[R_CA]),
      .wren  (rgn_wren[R_CA]),
      .rden  (rgn_rden[R_CA]),
      .q     (rgn_q[R_CA])
   );

   region_ram #(.AW(CART_B_AW)) u_cart_b (
      .clk   (clk),
      .addr  (rgn_addr[R_CB]),
      .wdata (rgn_wdata[R_CB]),
      .wren  (rgn_wren[R_CB]),
      .rden  (rgn_rden[R_CB]),
      .q     (rgn_q[R_CB])
   );

   // Enable sampled with the read so the gate lines up with RAM latency
   always_ff @(posedge clk) begin
      slot_en_q <= slot_en;
   end

   assign bios_q   = rgn_q[R_BIOS];
   assign ram_q    = rgn_q[R_RAM];
   assign cart_a_q = slot_en_q[0] ? rgn_q[R_CA] : 8'hFF;
   assign cart_b_q = slot_en_q[1] ? rgn_q[R_CB] : 8'hFF;

endmodule

//--- src/save_ram_sync.sv
`timescale 1ns/1ps

module save_ram_sync #(
   parameter int SRAM_AW = 13
) (
   input  logic                  clk,
   input  logic                  rst,
   input  logic                  img_mounted,
   input  logic                  img_readonly,
   input  logic [63:0]           img_size,
   input  logic                  sram_write,
   input  logic                  sd_ack,
   input  logic [13:0]           sd_buff_addr,
   input  logic [7:0]            sd_buff_dout,
   input  logic                  sd_buff_wr,
   output logic [31:0]           sd_lba,
   output logic                  sd_rd,
   output logic                  sd_wr,
   output logic [7:0]            sd_buff_din,
   input  msx_mem_pkg::mem_req_t sram_req,
   output logic [7:0]            sram_q
);

   localparam int BW          = msx_mem_pkg::SD_BLOCK_W;
   localparam int LBA_W       = SRAM_AW - BW;   // Block index bits inside the array
   localparam int SAVE_BLOCKS = 2 ** LBA_W;

   logic [7:0]         sram [2**SRAM_AW];
   logic               image_ok;
   logic [LBA_W:0]     load_blocks;
   logic               loaded;
   logic               write_rq;
   logic               old_ack;
   logic [31:0]        last_lba;
   logic [SRAM_AW-1:0] sd_addr;
   logic               sd_in_range;
   logic               cpu_in_range;
   logic [7:0]         cpu_rd_data;
   logic               cpu_rd_ok;

   assign sd_addr      = {sd_lba[LBA_W-1:0], sd_buff_addr[BW-1:0]};
   assign sd_in_range  = sd_lba[31:LBA_W] == '0 && sd_buff_addr[13:BW] == '0;
   assign cpu_in_range = sram_req.addr[msx_mem_pkg::MEM_ADDR_W-1:SRAM_AW] == '0;
   assign last_lba     = sd_wr ? 32'(SAVE_BLOCKS - 1) : 32'(load_blocks) - 32'd1;

   // SD side and CPU side of the save array
   always_ff @(posedge clk) begin
      if (sd_buff_wr && sd_rd && sd_in_range) begin
         sram[sd_addr] <= sd_buff_dout;
      end
      if (sram_req.wren && cpu_in_range) begin
         sram[sram_req.addr[SRAM_AW-1:0]] <= sram_req.wdata;
      end
      sd_buff_din <= sram[sd_addr];
      cpu_rd_data <= sram[sram_req.addr[SRAM_AW-1:0]];
      cpu_rd_ok   <= sram_req.rden && cpu_in_range;
   end

   assign sram_q = cpu_rd_ok ? cpu_rd_data : 8'hFF;

   always_ff @(posedge clk) begin
      if (img_mounted) begin
         load_blocks <= img_size[SRAM_AW:BW];
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         sd_rd    <= 1'b0;
         sd_wr    <= 1'b0;
         sd_lba   <= 32'd0;
         image_ok <= 1'b0;
         loaded   <= 1'b0;
         write_rq <= 1'b0;
         old_ack  <= 1'b0;
      end else begin
         old_ack <= sd_ack;
         if (!sd_rd && !sd_wr) begin
            if (image_ok && !loaded) begin
               if (load_blocks == '0) begin
                  loaded <= 1'b1;   // Empty image
               end else begin
                  sd_lba <= 32'd0;
                  sd_rd  <= 1'b1;
               end
            end else if (write_rq) begin
               sd_lba   <= 32'd0;
               sd_wr    <= 1'b1;
               write_rq <= 1'b0;
            end
         end else if (old_ack && !sd_ack) begin
            // Block done on falling ack
            if (sd_lba == last_lba) begin
               if (sd_rd) begin
                  loaded <= 1'b1;
               end
               sd_rd <= 1'b0;
               sd_wr <= 1'b0;
            end else begin
               sd_lba <= sd_lba + 32'd1;
            end
         end
         if (sram_write && image_ok) begin
            write_rq <= 1'b1;
         end
         if (img_mounted) begin
            image_ok <= !img_readonly && img_size <= (64'd1 << SRAM_AW);
            loaded   <= 1'b0;
            write_rq <= 1'b0;
         end
      end
   end

endmodule

//--- src/msx_memory_top.sv
`timescale 1ns/1ps

module msx_memory_top #(
   parameter int BIOS_AW   = 15,
   parameter int RAM_AW    = 16,
   parameter int CART_A_AW = 17,
   parameter int CART_B_AW = 16,
   parameter int SRAM_AW   = 13
) (
   input  logic                                                clk,
   input  logic                                                rst,
   input  msx_mem_pkg::mem_req_t [msx_mem_pkg::MEM_PORTS-1:0] mem_req,
   output logic [msx_mem_pkg::MEM_PORTS-1:0][7:0]             mem_q,
   input  msx_mem_pkg::dl_req_t                               dl,
   output logic                                                reset_req,
   input  logic [1:0]                                          cart_changed,
   input  logic                                                image_detach,
   input  logic                                                img_mounted,
   input  logic                                                img_readonly,
   input  logic [63:0]                                         img_size,
   output logic [31:0]                                         sd_lba,
   output logic                                                sd_rd,
   output logic                                                sd_wr,
   input  logic                                                sd_ack,
   input  logic [13:0]                                         sd_buff_addr,
   input  logic [7:0]                                          sd_buff_dout,
   output logic [7:0]                                          sd_buff_din,
   input  logic                                                sd_buff_wr,
   input  logic                                                sram_write
);

   msx_mem_pkg::dl_route_t route;
   logic [1:0]             slot_en;
   logic [1:0]             cart_wren;

   assign cart_wren = {mem_req[msx_mem_pkg::MEM_CART_B].wren,
                       mem_req[msx_mem_pkg::MEM_CART_A].wren};

   download_decode u_decode (
      .dl        (dl),
      .route     (route),
      .reset_req (reset_req)
   );

   cart_enable_regs u_enables (
      .clk          (clk),
      .rst          (rst),
      .route        (route),
      .cart_wren    (cart_wren),
      .cart_changed (cart_changed),
      .image_detach (image_detach),
      .slot_en      (slot_en)
   );

   memory_map #(
      .BIOS_AW   (BIOS_AW),
      .RAM_AW    (RAM_AW),
      .CART_A_AW (CART_A_AW),
      .CART_B_AW (CART_B_AW)
   ) u_map (
      .clk        (clk),
      .dl         (dl),
      .route      (route),
      .slot_en    (slot_en),
      .bios_req   (mem_req[msx_mem_pkg::MEM_BIOS]),
      .ram_req    (mem_req[msx_mem_pkg::MEM_RAM]),
      .cart_a_req (mem_req[msx_mem_pkg::MEM_CART_A]),
      .cart_b_req (mem_req[msx_mem_pkg::MEM_CART_B]),
      .bios_q     (mem_q[msx_mem_pkg::MEM_BIOS]),
      .ram_q      (mem_q[msx_mem_pkg::MEM_RAM]),
      .cart_a_q   (mem_q[msx_mem_pkg::MEM_CART_A]),
      .cart_b_q   (mem_q[msx_mem_pkg::MEM_CART_B])
   );

   save_ram_sync #(.SRAM_AW(SRAM_AW)) u_sram (
      .clk          (clk),
      .rst          (rst),
      .img_mounted  (img_mounted),
      .img_readonly (img_readonly),
      .img_size     (img_size),
      .sram_write   (sram_write),
      .sd_ack       (sd_ack),
      .sd_buff_addr (sd_buff_addr),
      .sd_buff_dout (sd_buff_dout),
      .sd_buff_wr   (sd_buff_wr),
      .sd_lba       (sd_lba),
      .sd_rd        (sd_rd),
      .sd_wr        (sd_wr),
      .sd_buff_din  (sd_buff_din),
      .sram_req     (mem_req[msx_mem_pkg::MEM_SRAM]),
      .sram_q       (mem_q[msx_mem_pkg::MEM_SRAM])
   );

endmodule

//--- dv/save_ram_sync_chk.sv
`timescale 1ns/1ps

module save_ram_sync_chk (
   input logic        clk,
   input logic        rst,
   input logic        sd_rd,
   input logic        sd_wr,
   input logic        sd_ack,
   input logic [31:0] sd_lba
);

   int assert_fails = 0;   // Count of failed assertions

   a_rd_wr_exclusive: assert property (@(posedge clk) disable iff (rst)
      !(sd_rd && sd_wr))
   else begin
      $error("sd_rd and sd_wr high together");
      assert_fails++;
   end

   // Block address frozen for the whole ack window
   a_lba_stable: assert property (@(posedge clk) disable iff (rst)
      sd_ack && $past(sd_ack) |-> $stable(sd_lba))
   else begin
      $error("sd_lba changed while sd_ack was high");
      assert_fails++;
   end

   a_idle_after_reset: assert property (@(posedge clk)
      rst |=> !sd_rd && !sd_wr)
   else begin
      $error("SD request high in the cycle after reset");
      assert_fails++;
   end

endmodule

//--- dv/tb_msx_memory.sv
`timescale 1ns/1ps

module tb_msx_memory;

   localparam int CLK_PERIOD      = 100;
   localparam int NUM_TESTS       = 5;
   localparam int CYCLES_PER_TEST = 4000;
   localparam int WATCHDOG_NS     = NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD;
   localparam int BIOS_SIZE       = 1 << 15;
   localparam int RAM_SIZE        = 1 << 16;
   localparam int CART_A_SIZE     = 1 << 17;
   localparam int CART_B_SIZE     = 1 << 16;
   localparam int SRAM_SIZE       = 1 << 13;
   localparam int SD_BLOCK        = 512;
   localparam int LOAD_BYTES      = 4096;
   localparam int SD_WAIT         = 50;   // Cycles the host waits for a request edge

   // Host download index codes
   localparam logic [15:0] IDX_BOOT     = 16'h0000;
   localparam logic [15:0] IDX_BIOS     = 16'h0001;
   localparam logic [15:0] IDX_BOOT_SUB = 16'h0040;
   localparam logic [15:0] IDX_UNKNOWN  = 16'h0003;
   localparam logic [15:0] IDX_CART_A   = 16'h0006;
   localparam logic [15:0] IDX_CART_B   = 16'h0009;

   logic                                              clk;
   logic                                              rst;
   msx_mem_pkg::mem_req_t [msx_mem_pkg::MEM_PORTS-1:0] mem_req;
   logic [msx_mem_pkg::MEM_PORTS-1:0][7:0]            mem_q;
   msx_mem_pkg::dl_req_t                              dl;
   logic                                              reset_req;
   logic [1:0]                                        cart_changed;
   logic                                              image_detach;
   logic                                              img_mounted;
   logic                                              img_readonly;
   logic [63:0]                                       img_size;
   logic [31:0]                                       sd_lba;
   logic                                              sd_rd;
   logic                                              sd_wr;
   logic                                              sd_ack;
   logic [13:0]                                       sd_buff_addr;
   logic [7:0]                                        sd_buff_dout;
   logic [7:0]                                        sd_buff_din;
   logic                                              sd_buff_wr;
   logic                                              sram_write;

   logic [7:0] bios_model [BIOS_SIZE];
   logic [7:0] ram_model [RAM_SIZE];
   logic [7:0] cart_a_model [CART_A_SIZE];
   logic [7:0] cart_b_model [CART_B_SIZE];
   logic [7:0] sram_model [SRAM_SIZE];
   logic [7:0] sd_image [SRAM_SIZE];   // Image held by the SD host
   int         mismatch_count = 0;
   int         failure_count = 0;

   msx_memory_top UUT (
      .clk          (clk),
      .rst          (rst),
      .mem_req      (mem_req),
      .mem_q        (mem_q),
      .dl           (dl),
      .reset_req    (reset_req),
      .cart_changed (cart_changed),
      .image_detach (image_detach),
      .img_mounted  (img_mounted),
      .img_readonly (img_readonly),
      .img_size     (img_size),
      .sd_lba       (sd_lba),
      .sd_rd        (sd_rd),
      .sd_wr        (sd_wr),
      .sd_ack       (sd_ack),
      .sd_buff_addr (sd_buff_addr),
      .sd_buff_dout (sd_buff_dout),
      .sd_buff_din  (sd_buff_din),
      .sd_buff_wr   (sd_buff_wr),
      .sram_write   (sram_write)
   );

   bind save_ram_sync save_ram_sync_chk u_chk (
      .clk    (clk),
      .rst    (rst),
      .sd_rd  (sd_rd),
      .sd_wr  (sd_wr),
      .sd_ack (sd_ack),
      .sd_lba (sd_lba)
   );

   initial clk = 1'b0;
   always #(CLK_PERIOD / 2) clk = ~clk;

   task automatic compare_value(input string name, input logic [31:0] got,
                                input logic [31:0] exp);
      assert (got === exp) else begin
         $display("mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
         mismatch_count++;
      end
   endtask

   task automatic check_condition(input bit cond, input string what);
      assert (cond) else begin
         $display("error: %s", what);
         failure_count++;
      end
   endtask

   task automatic cpu_write(input int port, input logic [24:0] addr, input logic [7:0] data);
      @(negedge clk);
      mem_req[port].addr  = addr;
      mem_req[port].wdata = data;
      mem_req[port].wren  = 1'b1;
      mem_req[port].rden  = 1'b0;
      @(negedge clk);
      mem_req[port].wren = 1'b0;
   endtask

   task automatic read_and_compare(input int port, input logic [24:0] addr,
                                   input logic [7:0] exp);
      logic [7:0] got;
      @(negedge clk);
      mem_req[port].addr = addr;
      mem_req[port].wren = 1'b0;
      mem_req[port].rden = 1'b1;
      @(negedge clk);
      got = mem_q[port];   // One cycle read latency
      mem_req[port].rden = 1'b0;
      compare_value($sformatf("mem_q[%0d] @0x%h", port, addr), got, exp);
   endtask

   // One download byte per cycle while the index stays active
   task automatic dl_write(input logic [15:0] index, input logic [26:0] addr,
                           input logic [7:0] data);
      @(negedge clk);
      dl.active = 1'b1;
      dl.index  = index;
      dl.wr     = 1'b1;
      dl.addr   = addr;
      dl.dout   = data;
   endtask

   task automatic dl_finish(input bit exp_reset);
      @(negedge clk);
      compare_value("reset_req", reset_req, exp_reset);
      dl.wr     = 1'b0;
      dl.active = 1'b0;
      @(negedge clk);
      compare_value("reset_req", reset_req, 0);
   endtask

   task automatic mount_image(input bit readonly, input logic [63:0] size);
      @(negedge clk);
      img_mounted  = 1'b1;
      img_readonly = readonly;
      img_size     = size;
      @(negedge clk);
      img_mounted = 1'b0;
   endtask

   task automatic wait_sd_state(input bit busy, output bit ok);
      int n;
      n = 0;
      while (n < SD_WAIT && (sd_rd || sd_wr) != busy) begin
         @(negedge clk);
         n++;
      end
      ok = (sd_rd || sd_wr) == busy;
   endtask

   // SD host side, one ack window per block
   task automatic serve_sd(input bit save, input int blocks);
      bit ok;
      int base;
      for (int b = 0; b < blocks; b++) begin
         wait_sd_state(1'b1, ok);
         if (!ok) begin
            check_condition(1'b0, $sformatf("no SD request for block %0d", b));
            return;
         end
         compare_value("sd_lba", sd_lba, b);
         compare_value(save ? "sd_wr" : "sd_rd", save ? sd_wr : sd_rd, 1);
         base   = b * SD_BLOCK;
         sd_ack = 1'b1;
         if (save) begin
            for (int i = 0; i <= SD_BLOCK; i++) begin
               @(negedge clk);
               if (i > 0) begin
                  compare_value("sd_buff_din", sd_buff_din, sram_model[base + i - 1]);
               end
               if (i < SD_BLOCK) begin
                  sd_buff_addr = 14'(i);
               end
            end
         end else begin
            for (int i = 0; i < SD_BLOCK; i++) begin
               @(negedge clk);
               sd_buff_addr = 14'(i);
               sd_buff_dout = sd_image[base + i];
               sd_buff_wr   = 1'b1;
               sram_model[base + i] = sd_image[base + i];
            end
            @(negedge clk);
            sd_buff_wr = 1'b0;
         end
         sd_ack = 1'b0;
         @(negedge clk);
      end
      wait_sd_state(1'b0, ok);
      check_condition(ok, "SD request still high after the last block");
   endtask

   task automatic bios_download();
      logic [24:0] a;
      logic [7:0]  d;
      logic [24:0] addrs[$];
      for (int pass = 0; pass < 2; pass++) begin
         for (int i = 0; i < 16; i++) begin
            a = 25'($urandom % BIOS_SIZE);
            d = 8'($urandom);
            dl_write(pass == 0 ? IDX_BIOS : IDX_BOOT, 27'(a), d);
            bios_model[a] = d;
            addrs.push_back(a);
         end
         dl_finish(1'b1);
      end
      // Unrecognized indexes must leave the BIOS untouched
      dl_write(IDX_BOOT_SUB, 27'(addrs[0]), ~bios_model[addrs[0]]);
      dl_finish(1'b0);
      dl_write(IDX_UNKNOWN, 27'(addrs[1]), ~bios_model[addrs[1]]);
      dl_finish(1'b0);
      foreach (addrs[i]) begin
         read_and_compare(msx_mem_pkg::MEM_BIOS, addrs[i], bios_model[addrs[i]]);
      end
   endtask

   task automatic main_ram_rw();
      logic [24:0] a;
      logic [7:0]  d;
      logic [24:0] addrs[$];
      for (int i = 0; i < 48; i++) begin
         a = 25'($urandom % RAM_SIZE);
         d = 8'($urandom);
         cpu_write(msx_mem_pkg::MEM_RAM, a, d);
         ram_model[a] = d;
         addrs.push_back(a);
      end
      foreach (addrs[i]) begin
         read_and_compare(msx_mem_pkg::MEM_RAM, addrs[i], ram_model[addrs[i]]);
      end
      a = addrs[0] | 25'(RAM_SIZE);   // Aliases a stored byte above the region
      cpu_write(msx_mem_pkg::MEM_RAM, a, ~ram_model[addrs[0]]);
      read_and_compare(msx_mem_pkg::MEM_RAM, a, 8'hFF);
      read_and_compare(msx_mem_pkg::MEM_RAM, 25'h1FF_FFFF, 8'hFF);
      read_and_compare(msx_mem_pkg::MEM_RAM, addrs[0], ram_model[addrs[0]]);
   endtask

   task automatic cart_slot_enable();
      logic [24:0] a;
      logic [7:0]  d;
      logic [24:0] a_addrs[$];
      logic [24:0] b_addrs[$];
      read_and_compare(msx_mem_pkg::MEM_CART_A, 25'h0, 8'hFF);
      read_and_compare(msx_mem_pkg::MEM_CART_B, 25'h0, 8'hFF);
      for (int i = 0; i < 16; i++) begin
         a = 25'($urandom % CART_A_SIZE);
         d = 8'($urandom);
         dl_write(IDX_CART_A, 27'(a), d);
         cart_a_model[a] = d;
         a_addrs.push_back(a);
      end
      dl_finish(1'b1);
      for (int i = 0; i < 16; i++) begin
         a = 25'($urandom % CART_B_SIZE);
         d = 8'($urandom);
         dl_write(IDX_CART_B, 27'(a), d);
         cart_b_model[a] = d;
         b_addrs.push_back(a);
      end
      dl_finish(1'b1);
      foreach (a_addrs[i]) begin
         read_and_compare(msx_mem_pkg::MEM_CART_A, a_addrs[i], cart_a_model[a_addrs[i]]);
      end
      foreach (b_addrs[i]) begin
         read_and_compare(msx_mem_pkg::MEM_CART_B, b_addrs[i], cart_b_model[b_addrs[i]]);
      end
      @(negedge clk);
      cart_changed = 2'b10;
      @(negedge clk);
      cart_changed = 2'b00;
      read_and_compare(msx_mem_pkg::MEM_CART_B, b_addrs[0], 8'hFF);
      read_and_compare(msx_mem_pkg::MEM_CART_A, a_addrs[0], cart_a_model[a_addrs[0]]);
      d = 8'($urandom);
      cpu_write(msx_mem_pkg::MEM_CART_B, b_addrs[1], d);   // Re-enables slot B
      cart_b_model[b_addrs[1]] = d;
      foreach (b_addrs[i]) begin
         read_and_compare(msx_mem_pkg::MEM_CART_B, b_addrs[i], cart_b_model[b_addrs[i]]);
      end
      @(negedge clk);
      image_detach = 1'b1;
      @(negedge clk);
      image_detach = 1'b0;
      read_and_compare(msx_mem_pkg::MEM_CART_A, a_addrs[0], 8'hFF);
      read_and_compare(msx_mem_pkg::MEM_CART_B, b_addrs[0], 8'hFF);
   endtask

   task automatic sram_image_load();
      bit          seen;
      logic [24:0] a;
      seen = 1'b0;
      mount_image(1'b1, 64'(LOAD_BYTES));
      repeat (20) begin
         @(negedge clk);
         seen = seen || sd_rd || sd_wr;
      end
      check_condition(!seen, "SD request after a read-only mount");
      mount_image(1'b0, 64'(LOAD_BYTES));
      serve_sd(1'b0, LOAD_BYTES / SD_BLOCK);
      for (int i = 0; i < 64; i++) begin
         a = 25'($urandom % LOAD_BYTES);
         read_and_compare(msx_mem_pkg::MEM_SRAM, a, sram_model[a]);
      end
   endtask

   task automatic sram_image_store();
      logic [24:0] a;
      logic [7:0]  d;
      // Scattered edits in the loaded half, then fill the upper half
      for (int i = 0; i < 32 + SRAM_SIZE - LOAD_BYTES; i++) begin
         a = (i < 32) ? 25'($urandom % LOAD_BYTES) : 25'(LOAD_BYTES + i - 32);
         d = 8'($urandom);
         @(negedge clk);
         mem_req[msx_mem_pkg::MEM_SRAM].addr  = a;
         mem_req[msx_mem_pkg::MEM_SRAM].wdata = d;
         mem_req[msx_mem_pkg::MEM_SRAM].wren  = 1'b1;
         sram_model[a] = d;
      end
      @(negedge clk);
      mem_req[msx_mem_pkg::MEM_SRAM].wren = 1'b0;
      sram_write = 1'b1;
      @(negedge clk);
      sram_write = 1'b0;
      serve_sd(1'b1, SRAM_SIZE / SD_BLOCK);
   endtask

   initial begin
      int total;
      void'($urandom(32'hf59a_437b));
      rst          = 1'b1;
      mem_req      = '0;
      dl           = '0;
      cart_changed = 2'b00;
      image_detach = 1'b0;
      img_mounted  = 1'b0;
      img_readonly = 1'b0;
      img_size     = 64'd0;
      sd_ack       = 1'b0;
      sd_buff_addr = 14'd0;
      sd_buff_dout = 8'h00;
      sd_buff_wr   = 1'b0;
      sram_write   = 1'b0;
      for (int i = 0; i < SRAM_SIZE; i++) begin
         sd_image[i] = 8'($urandom);
      end
      repeat (10) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
      bios_download();
      main_ram_rw();
      cart_slot_enable();
      sram_image_load();
      sram_image_store();
      total = mismatch_count + failure_count + UUT.u_sram.u_chk.assert_fails;
      $display("errors: %0d mismatches, %0d other failures, %0d assertion failures",
               mismatch_count, failure_count, UUT.u_sram.u_chk.assert_fails);
      if (total == 0) begin
         $display("*** TEST PASSED ***");
      end else begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

   initial begin
      #(WATCHDOG_NS);
      $display("error: run did not finish within %0d cycles", WATCHDOG_NS / CLK_PERIOD);
      $display("errors: %0d mismatches, %0d other failures, %0d assertion failures",
               mismatch_count, failure_count + 1, UUT.u_sram.u_chk.assert_fails);
      $display("*** TEST FAILED ***");
      $finish;
   end

endmodule

//--- tb.f
src/msx_mem_pkg.sv
src/download_decode.sv
src/region_ram.sv
src/cart_enable_regs.sv
src/memory_map.sv
src/save_ram_sync.sv
src/msx_memory_top.sv
dv/save_ram_sync_chk.sv
dv/tb_msx_memory.sv
